// ==== Bender.yml ====
package:
  name: id_subsys

export_include_dirs:
  - .

sources:
  - id_mgmt_pkg.sv
  - id_fetch_if.sv
  - fetch_unit.sv
  - id_tracker.sv
  - issue_unit.sv
  - id_subsys_top.sv
  - target: test
    files:
      - id_subsys_props.sv
      - id_subsys_tb.sv

// ==== fetch_unit.sv ====
////////////////////////////////////////
// Fetch unit: ID allocation and Wishbone
// classic instruction reads
////////////////////////////////////////

`timescale 1ns/10ps

module fetch_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic [31:0] redirect_pc,
    id_fetch_if.fetch   fetch,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack
);

    // Bus cycle states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        DISCARD
    } fetch_state_t;

    fetch_state_t state;
    logic [31:0]  next_pc;
    logic         start_req;
    logic         assign_pulse;

    // New request only with a free ID and no redirect pending
    assign start_req = (state == IDLE) & ~flush & fetch.pc_id_available;

    ////////////////////////////////////////
    // Control FSM and next PC
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            assign_pulse <= 1'b0;
            // Program starts at address zero
            next_pc      <= '0;
        end else begin
            // ID goes out in the first cycle of the request
            assign_pulse <= start_req;
            case (state)
                IDLE: if (start_req) state <= WAIT_ACK;
                WAIT_ACK: begin
                    if (wb_ack)
                        state <= IDLE;
                    else if (flush)
                        state <= DISCARD;
                end
                // Open read is stale, drain it
                DISCARD: if (wb_ack) state <= IDLE;
                default: state <= IDLE;
            endcase
            if (flush)
                next_pc <= redirect_pc;
            else if (start_req)
                next_pc <= next_pc + 32'd4;
        end
    end

    // Address held for the whole cycle
    always_ff @(posedge clk) begin
        if (start_req)
            wb_adr <= next_pc;
    end

    ////////////////////////////////////////
    // Bus side, read only
    assign wb_cyc = (state != IDLE);
    assign wb_stb = (state != IDLE);
    assign wb_we  = 1'b0;

    // Tracker side
    assign fetch.pc_id_assigned    = assign_pulse;
    assign fetch.if_pc             = wb_adr;
    // Data in the flush cycle belongs to the old path
    assign fetch.fetch_complete    = (state == WAIT_ACK) & wb_ack & ~flush;
    assign fetch.fetch_instruction = wb_dat_i;

endmodule

// ==== id_fetch_if.sv ====
////////////////////////////////////////
// ID allocation and fetch completion link
////////////////////////////////////////

`timescale 1ns/10ps

interface id_fetch_if;
    import id_mgmt_pkg::*;

    // ID handed out to the next fetch
    id_t         pc_id;
    logic        pc_id_available;
    // ID of the oldest fetch still on the bus
    id_t         fetch_id;

    // Allocation strobe with the fetched PC
    logic        pc_id_assigned;
    logic [31:0] if_pc;

    // Instruction word returned by the bus
    logic        fetch_complete;
    logic [31:0] fetch_instruction;

    // Fetch side allocates and returns words
    modport fetch (
        input  pc_id, pc_id_available, fetch_id,
        output pc_id_assigned, if_pc, fetch_complete, fetch_instruction
    );

    // Tracker side owns the pointers
    modport tracker (
        output pc_id, pc_id_available, fetch_id,
        input  pc_id_assigned, if_pc, fetch_complete, fetch_instruction
    );

endinterface

// ==== id_mgmt_cfg.svh ====
////////////////////////////////////////
// Pool size, ID width, retire width and
// multiply latency of the ID subsystem
////////////////////////////////////////

`ifndef ID_MGMT_CFG_SVH
`define ID_MGMT_CFG_SVH

// Number of instruction IDs in the pool
`define MAX_IDS 8

// Bits of one ID, log2 of the pool size
`define ID_W 3

// Most IDs freed by the retirer per cycle
`define RETIRE_PORTS 2

// Issue to writeback distance of a multiply
`define MUL_LATENCY 3

`endif

// ==== id_mgmt_pkg.sv ====
////////////////////////////////////////
// Shared types: ID, instruction word views,
// decode and retire packets, opcodes
////////////////////////////////////////

`include "id_mgmt_cfg.svh"

package id_mgmt_pkg;

    // Instruction ID, wraps around the pool
    typedef logic [`ID_W-1:0] id_t;

    // Major opcodes seen by the issue unit
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // Immediate layout
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // Same 32 bits, decoded either way
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_word_u;

    // Oldest fetched instruction, toward decode
    typedef struct packed {
        logic        valid;
        id_t         id;
        logic [31:0] pc;
        instr_word_u instruction;
    } decode_packet_t;

    // One cycle of retirement
    typedef struct packed {
        logic [1:0]  count;
        logic        rd_valid;
        logic [31:0] pc;
    } retire_packet_t;

endpackage

// ==== id_subsys_cases.txt ====
// kind_flag_address_word, kind 0 word, 1 hold, 2 release, 3 flush to address,
// 4 wait until retirement reaches address, F end; flag is the expected rd write
0_1_00000000_00100093
0_1_00000004_00128293
0_1_00000008_002081B3
0_1_0000000C_02208233
0_0_00000010_00000013
0_1_00000014_02208233
0_0_00000018_0020A023
0_1_0000001C_002081B3
0_0_00000020_02208033
0_1_00000024_00128293
0_0_00000028_000012B7
0_1_0000002C_02208233
0_1_00000030_02208233
0_0_00000034_00000013
0_1_00000038_00100093
0_1_0000003C_002081B3
0_1_00000100_02208233
0_1_00000104_00100093
0_0_00000108_00000013
0_1_0000010C_00128293
0_1_00000110_02208233
0_0_00000114_0020A023
0_1_00000118_002081B3
0_1_0000011C_00100093
4_0_00000020_00000000
1_0_00000000_00000000
2_0_00000000_00000000
4_0_00000030_00000000
1_0_00000000_00000000
3_0_00000100_00000000
2_0_00000000_00000000
4_0_00000120_00000000
F_0_00000000_00000000

// ==== id_subsys_props.sv ====
////////////////////////////////////////
// ID accounting assertions on the tracker
////////////////////////////////////////

`timescale 1ns/10ps
`include "id_mgmt_cfg.svh"

module id_subsys_props (
    input logic           clk,
    input logic           rst,
    input logic           pc_id_assigned,
    input logic           pc_id_available,
    input logic           decode_advance,
    input logic           decode_valid,
    input logic [`ID_W:0] post_issue_count,
    input logic [1:0]     retire_count
);

    // Assignment strobe trails the request by one cycle
    assert property (@(posedge clk) disable iff (rst)
        pc_id_assigned |-> $past(pc_id_available))
        else $error("ID assigned while none was free");

    // Decode only moves on a valid packet
    assert property (@(posedge clk) disable iff (rst)
        decode_advance |-> decode_valid)
        else $error("decode_advance without decode.valid");

    assert property (@(posedge clk) disable iff (rst)
        post_issue_count <= (`ID_W+1)'(`MAX_IDS))
        else $error("post_issue_count above pool size");

    // Retire width limit
    assert property (@(posedge clk) disable iff (rst)
        retire_count <= 2'(`RETIRE_PORTS))
        else $error("retire count above retire width");

endmodule

bind id_tracker id_subsys_props i_id_subsys_props (
    .clk              (clk),
    .rst              (rst),
    .pc_id_assigned   (fetch.pc_id_assigned),
    .pc_id_available  (fetch.pc_id_available),
    .decode_advance   (decode_advance),
    .decode_valid     (decode.valid),
    .post_issue_count (post_issue_count),
    .retire_count     (retire.count)
);

// ==== id_subsys_tb.sv ====
////////////////////////////////////////
// Testbench: clock, Wishbone memory model,
// cases file stimulus, retire checks
////////////////////////////////////////

`timescale 1ns/10ps
`include "id_mgmt_cfg.svh"

module id_subsys_tb;
    import id_mgmt_pkg::*;

    // Entry kinds in the cases file
    localparam logic [3:0] K_WORD    = 4'h0;
    localparam logic [3:0] K_HOLD    = 4'h1;
    localparam logic [3:0] K_RELEASE = 4'h2;
    localparam logic [3:0] K_FLUSH   = 4'h3;
    localparam logic [3:0] K_WAIT    = 4'h4;
    localparam logic [3:0] K_END     = 4'hF;

    logic           clk;
    logic           rst;
    logic           hold;
    logic           flush;
    logic [31:0]    redirect_pc;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    logic [31:0]    wb_adr;
    logic [31:0]    wb_dat_i;
    logic           wb_ack;
    logic [1:0]     retire_count;
    logic           retire_rd_valid;
    logic [31:0]    retire_pc;
    logic [`ID_W:0] post_issue_count;

    logic [71:0]    cases [0:63];
    logic [31:0]    mem_words [logic [31:0]];
    logic           rd_flags [logic [31:0]];
    logic [31:0]    expected_pc;
    logic [31:0]    start_pc;
    integer         seed = 32'h00b85b22;
    integer         error_count = 0;
    integer         cycle_count = 0;
    integer         cycle_limit = 1000000;
    integer         ack_wait = -1;
    integer         outstanding = 0;
    logic           drained;

    id_subsys_top i_id_subsys_top (.*);

    ////////////////////////////////////////
    // Check helpers
    task automatic stop_run(input string why);
        error_count++;
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_count(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_ids(input string name, input logic [`ID_W:0] got,
                             input logic [`ID_W:0] exp);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Unlisted addresses hold an OP-IMM with rd zero and an imm folded from the address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [11:0] imm;
        imm = addr[31:20] ^ addr[19:8] ^ {addr[7:0], 4'h0};
        return {imm, 5'd0, 3'd0, 5'd0, OPCODE_OP_IMM};
    endfunction

    function automatic logic flag_of(input logic [31:0] addr);
        if (rd_flags.exists(addr))
            return rd_flags[addr];
        return 1'b0;
    endfunction

    ////////////////////////////////////////
    // Clock and timeout
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > cycle_limit)
                stop_run("Timeout, retirement did not reach the expected address");
        end
    end

    ////////////////////////////////////////
    // Wishbone memory with random ack delay
    initial begin
        wb_ack   = 1'b0;
        wb_dat_i = '0;
        forever begin
            @(posedge clk);
            #1;
            if (wb_ack) begin
                wb_ack = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (ack_wait < 0)
                    ack_wait = $unsigned($random(seed)) % 4;
                if (ack_wait == 0) begin
                    wb_ack   = 1'b1;
                    wb_dat_i = mem_words.exists(wb_adr) ? mem_words[wb_adr] : fill_word(wb_adr);
                    ack_wait = -1;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Retire monitor sampled mid-cycle
    initial begin
        logic        exp_rd;
        integer      flagged;
        logic [31:0] pc;
        logic        cyc_seen;
        drained  = 1'b0;
        cyc_seen = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (wb_cyc)
                    check_flag("wb_we", wb_we, 1'b0);
                // Nothing retires once the held pipeline is empty
                if (hold && drained)
                    check_count("retire_count", retire_count, 2'd0);
                if (retire_count > 2'(`RETIRE_PORTS))
                    stop_run("More instructions retired in one cycle than the retire width");
                if (retire_count != 2'd0) begin
                    check_pc("retire_pc", retire_pc, expected_pc);
                    exp_rd  = 1'b0;
                    flagged = 0;
                    for (int k = 0; k < retire_count; k++) begin
                        pc = expected_pc + 32'(4 * k);
                        exp_rd = exp_rd | flag_of(pc);
                        flagged += flag_of(pc);
                    end
                    if (flagged > 1)
                        stop_run("Two register-writing instructions retired together");
                    check_flag("retire_rd_valid", retire_rd_valid, exp_rd);
                    expected_pc = expected_pc + 32'(4 * retire_count);
                    outstanding = outstanding - retire_count;
                end
                // One ID per bus request, all returned by a flush on a drained pipeline
                if (flush)
                    outstanding = 0;
                else if (wb_cyc && !cyc_seen)
                    outstanding++;
                cyc_seen = wb_cyc;
                drained = hold && (drained || post_issue_count == '0);
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus from the cases file
    initial begin
        integer      words;
        integer      stable;
        logic [3:0]  kind;
        logic [31:0] addr;
        rst         = 1'b1;
        hold        = 1'b0;
        flush       = 1'b0;
        redirect_pc = '0;
        $readmemh("id_subsys_cases.txt", cases);
        words    = 0;
        start_pc = 'x;
        for (int i = 0; i < 64 && cases[i][71:68] !== K_END; i++) begin
            if (cases[i][71:68] == K_WORD) begin
                if (words == 0)
                    start_pc = cases[i][63:32];
                mem_words[cases[i][63:32]] = cases[i][31:0];
                rd_flags[cases[i][63:32]]  = cases[i][64];
                words++;
            end
        end
        cycle_limit = 40 * words + 200;
        expected_pc = start_pc;

        // Two reset cycles, then the idle state
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_flag("wb_cyc", wb_cyc, 1'b0);
        check_flag("wb_stb", wb_stb, 1'b0);
        check_count("retire_count", retire_count, 2'd0);
        check_ids("post_issue_count", post_issue_count, '0);
        do @(negedge clk); while (!wb_cyc);
        check_pc("wb_adr", wb_adr, start_pc);

        for (int i = 0; i < 64 && cases[i][71:68] !== K_END; i++) begin
            kind = cases[i][71:68];
            addr = cases[i][63:32];
            case (kind)
                K_HOLD: begin
                    @(posedge clk);
                    #1 hold = 1'b1;
                    // Pipeline empty and the pool full
                    stable = 0;
                    while (stable < 3) begin
                        @(negedge clk);
                        if (post_issue_count == '0 && !wb_stb)
                            stable++;
                        else
                            stable = 0;
                    end
                    repeat (2 * `MAX_IDS) begin
                        @(negedge clk);
                        check_flag("wb_stb", wb_stb, 1'b0);
                        check_ids("post_issue_count", post_issue_count, '0);
                    end
                    check_ids("outstanding_ids", (`ID_W+1)'(outstanding),
                              (`ID_W+1)'(`MAX_IDS));
                end
                K_RELEASE: begin
                    @(posedge clk);
                    #1 hold = 1'b0;
                end
                K_FLUSH: begin
                    if (!hold || post_issue_count != '0)
                        stop_run("Flush entry reached while the pipeline was not drained");
                    @(posedge clk);
                    #1;
                    flush       = 1'b1;
                    redirect_pc = addr;
                    expected_pc = addr;
                    @(posedge clk);
                    #1 flush = 1'b0;
                end
                K_WAIT: begin
                    while (expected_pc < addr)
                        @(negedge clk);
                end
                default: ;
            endcase
        end

        if (error_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

// ==== id_subsys_top.sv ====
////////////////////////////////////////
// Subsystem top: fetch, ID tracker, issue
////////////////////////////////////////

`timescale 1ns/10ps
`include "id_mgmt_cfg.svh"

module id_subsys_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           hold,
    input  logic           flush,
    input  logic [31:0]    redirect_pc,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output logic [31:0]    wb_adr,
    input  logic [31:0]    wb_dat_i,
    input  logic           wb_ack,
    output logic [1:0]     retire_count,
    output logic           retire_rd_valid,
    output logic [31:0]    retire_pc,
    output logic [`ID_W:0] post_issue_count
);
    import id_mgmt_pkg::*;

    // Fetch to tracker link
    id_fetch_if fetch_bus ();

    // Tracker to issue path
    decode_packet_t decode;
    logic           decode_advance;
    logic           decode_uses_rd;
    logic           instruction_issued;
    logic           issue_multicycle;
    id_t            issue_id;
    id_t            wb_id;
    logic           wb_valid;
    retire_packet_t retire;

    fetch_unit i_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .fetch       (fetch_bus.fetch),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack)
    );

    id_tracker i_id_tracker (
        .clk                (clk),
        .rst                (rst),
        .flush              (flush),
        .fetch              (fetch_bus.tracker),
        .decode             (decode),
        .decode_advance     (decode_advance),
        .decode_uses_rd     (decode_uses_rd),
        .instruction_issued (instruction_issued),
        .issue_multicycle   (issue_multicycle),
        .issue_id           (issue_id),
        .wb_id              (wb_id),
        .wb_valid           (wb_valid),
        .retire             (retire),
        .post_issue_count   (post_issue_count)
    );

    issue_unit i_issue_unit (
        .clk                (clk),
        .rst                (rst),
        .hold               (hold),
        .decode             (decode),
        .decode_advance     (decode_advance),
        .decode_uses_rd     (decode_uses_rd),
        .instruction_issued (instruction_issued),
        .issue_multicycle   (issue_multicycle),
        .issue_id           (issue_id),
        .wb_id              (wb_id),
        .wb_valid           (wb_valid)
    );

    // Retire packet out as plain ports
    assign retire_count    = retire.count;
    assign retire_rd_valid = retire.rd_valid;
    assign retire_pc       = retire.pc;

endmodule

// ==== id_tracker.sv ====
////////////////////////////////////////
// ID tracker: PC and instruction tables,
// ID counters, in-use bits, in-order retirer
////////////////////////////////////////

`timescale 1ns/10ps
`include "id_mgmt_cfg.svh"

module id_tracker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    id_fetch_if.tracker                 fetch,
    output id_mgmt_pkg::decode_packet_t decode,
    input  logic                        decode_advance,
    input  logic                        decode_uses_rd,
    input  logic                        instruction_issued,
    input  logic                        issue_multicycle,
    input  id_mgmt_pkg::id_t            issue_id,
    input  id_mgmt_pkg::id_t            wb_id,
    input  logic                        wb_valid,
    output id_mgmt_pkg::retire_packet_t retire,
    output logic [`ID_W:0]              post_issue_count
);
    import id_mgmt_pkg::*;

    localparam int CNT_W = `ID_W + 1;

    // Per-ID tables
    logic [31:0]  pc_table [`MAX_IDS];
    instr_word_u  instr_table [`MAX_IDS];
    logic         uses_rd_table [`MAX_IDS];
    logic [`MAX_IDS-1:0] id_inuse;
    logic [`MAX_IDS-1:0] issue_toggle;
    logic [`MAX_IDS-1:0] wb_toggle;

    id_t decode_id;
    id_t oldest_pre_issue_id;
    id_t oldest_next;
    id_t retire_base_id;
    id_t retire_ids [`RETIRE_PORTS];

    logic [CNT_W-1:0] fetched_count_neg;
    logic [CNT_W-1:0] pre_issue_count;
    logic [CNT_W-1:0] pre_issue_count_next;
    logic [CNT_W-1:0] post_issue_count_next;
    logic [CNT_W-1:0] inflight_count;

    retire_packet_t              retire_next;
    logic [`RETIRE_PORTS-1:0]    slot_ready;
    logic [`RETIRE_PORTS-1:0]    slot_retires;
    logic [`RETIRE_PORTS:0]      contiguous;
    logic [`RETIRE_PORTS:0]      rd_taken;

    ////////////////////////////////////////
    // Tables, written one cycle before read
    always_ff @(posedge clk) begin
        if (fetch.pc_id_assigned)
            pc_table[fetch.pc_id] <= fetch.if_pc;
        if (fetch.fetch_complete)
            instr_table[fetch.fetch_id] <= fetch.fetch_instruction;
        if (decode_advance)
            uses_rd_table[decode_id] <= decode_uses_rd;
    end

    ////////////////////////////////////////
    // ID pointers
    // Flush rewinds everything to the oldest ID not yet issued
    assign oldest_next = oldest_pre_issue_id + id_t'(instruction_issued);

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch.pc_id         <= '0;
            fetch.fetch_id      <= '0;
            decode_id           <= '0;
            oldest_pre_issue_id <= '0;
        end else begin
            oldest_pre_issue_id <= oldest_next;
            if (flush) begin
                fetch.pc_id    <= oldest_next;
                fetch.fetch_id <= oldest_next;
                decode_id      <= oldest_next;
            end else begin
                fetch.pc_id    <= fetch.pc_id + id_t'(fetch.pc_id_assigned);
                fetch.fetch_id <= fetch.fetch_id + id_t'(fetch.fetch_complete);
                decode_id      <= decode_id + id_t'(decode_advance);
            end
        end
    end

    ////////////////////////////////////////
    // Counters
    // Negative count, MSB set while a fetched word waits for decode
    always_ff @(posedge clk) begin
        if (rst || flush)
            fetched_count_neg <= '0;
        else
            fetched_count_neg <= fetched_count_neg + CNT_W'(decode_advance)
                                 - CNT_W'(fetch.fetch_complete);
    end

    assign pre_issue_count_next = pre_issue_count + CNT_W'(fetch.pc_id_assigned)
                                  - CNT_W'(instruction_issued);
    assign post_issue_count_next = post_issue_count + CNT_W'(instruction_issued)
                                   - CNT_W'(retire_next.count);

    always_ff @(posedge clk) begin
        if (rst || flush)
            pre_issue_count <= '0;
        else
            pre_issue_count <= pre_issue_count_next;
    end

    // Issued IDs survive a flush until retired
    always_ff @(posedge clk) begin
        if (rst) begin
            post_issue_count <= '0;
            inflight_count   <= '0;
        end else begin
            post_issue_count <= post_issue_count_next;
            if (flush)
                inflight_count <= post_issue_count_next;
            else
                inflight_count <= pre_issue_count_next + post_issue_count_next;
        end
    end

    ////////////////////////////////////////
    // In-use toggles for multicycle ops
    // Set by multiply issue, cleared by its writeback
    assign issue_toggle = (instruction_issued & issue_multicycle) ?
                          (`MAX_IDS'(1) << issue_id) : '0;
    assign wb_toggle    = wb_valid ? (`MAX_IDS'(1) << wb_id) : '0;

    always_ff @(posedge clk) begin
        if (rst)
            id_inuse <= '0;
        else
            id_inuse <= id_inuse ^ issue_toggle ^ wb_toggle;
    end

    ////////////////////////////////////////
    // Retirer
    // Slot i looks at the i-th oldest issued ID
    genvar g;
    for (g = 0; g < `RETIRE_PORTS; g++) begin : g_retire_slot
        assign retire_ids[g] = retire_base_id + id_t'(g);
    end

    // Contiguous run from slot 0, one rd writer at most
    always_comb begin
        contiguous[0]         = 1'b1;
        rd_taken[0]           = 1'b0;
        retire_next.count     = '0;
        retire_next.pc        = pc_table[retire_base_id];
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            slot_ready[i]     = (post_issue_count > CNT_W'(i)) & contiguous[i]
                                & ~id_inuse[retire_ids[i]];
            slot_retires[i]   = slot_ready[i]
                                & (~uses_rd_table[retire_ids[i]] | ~rd_taken[i]);
            contiguous[i+1]   = contiguous[i] & slot_retires[i];
            rd_taken[i+1]     = rd_taken[i] | (slot_retires[i] & uses_rd_table[retire_ids[i]]);
            retire_next.count = retire_next.count + 2'(slot_retires[i]);
        end
        retire_next.rd_valid  = rd_taken[`RETIRE_PORTS];
    end

    always_ff @(posedge clk) begin
        if (rst)
            retire_base_id <= '0;
        else
            retire_base_id <= retire_base_id + id_t'(retire_next.count);
    end

    // Packet shows up one cycle after the retire decision
    always_ff @(posedge clk) begin
        if (rst)
            retire <= '0;
        else
            retire <= retire_next;
    end

    ////////////////////////////////////////
    // Outputs
    assign fetch.pc_id_available = ~inflight_count[`ID_W];

    assign decode.valid       = fetched_count_neg[`ID_W];
    assign decode.id          = decode_id;
    assign decode.pc          = pc_table[decode_id];
    assign decode.instruction = instr_table[decode_id];

endmodule

// ==== issue_unit.sv ====
////////////////////////////////////////
// Issue unit: decode, in-order issue and
// the single multicycle multiply slot
////////////////////////////////////////

`timescale 1ns/10ps
`include "id_mgmt_cfg.svh"

module issue_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hold,
    input  id_mgmt_pkg::decode_packet_t decode,
    output logic                       decode_advance,
    output logic                       decode_uses_rd,
    output logic                       instruction_issued,
    output logic                       issue_multicycle,
    output id_mgmt_pkg::id_t           issue_id,
    output id_mgmt_pkg::id_t           wb_id,
    output logic                       wb_valid
);
    import id_mgmt_pkg::*;

    localparam int CNT_W = $clog2(`MUL_LATENCY + 1);

    instr_word_u      word;
    logic             is_alu_op;
    logic             writes_rd;
    logic             is_mul;
    logic             mul_busy;
    logic             mul_issue;
    logic [CNT_W-1:0] mul_count;

    ////////////////////////////////////////
    // Decode
    assign word = decode.instruction;

    // OP and OP-IMM share the rd field position
    assign is_alu_op = (word.i_view.opcode == OPCODE_OP) |
                       (word.i_view.opcode == OPCODE_OP_IMM);
    assign writes_rd = is_alu_op & (word.i_view.rd != 5'd0);

    // M extension, funct7 of 1 on the OP opcode
    assign is_mul = (word.r_view.opcode == OPCODE_OP) & (word.r_view.funct7 == 7'd1);

    ////////////////////////////////////////
    // Issue
    // A new multiply may enter in its predecessor's writeback cycle
    assign mul_busy = (mul_count > CNT_W'(1));

    assign decode_advance     = decode.valid & ~hold & ~(is_mul & mul_busy);
    assign instruction_issued = decode_advance;
    assign decode_uses_rd     = writes_rd;
    assign issue_id           = decode.id;
    assign mul_issue          = decode_advance & is_mul;
    assign issue_multicycle   = mul_issue;

    ////////////////////////////////////////
    // Multiply unit
    // Counts down to writeback
    always_ff @(posedge clk) begin
        if (rst)
            mul_count <= '0;
        else if (mul_issue)
            mul_count <= CNT_W'(`MUL_LATENCY);
        else if (mul_count != '0)
            mul_count <= mul_count - CNT_W'(1);
    end

    always_ff @(posedge clk) begin
        if (mul_issue)
            wb_id <= decode.id;
    end

    // Last count cycle is MUL_LATENCY after issue
    assign wb_valid = (mul_count == CNT_W'(1));

endmodule

// ==== sources.f ====
+incdir+.
id_mgmt_pkg.sv
id_fetch_if.sv
fetch_unit.sv
id_tracker.sv
issue_unit.sv
id_subsys_top.sv
id_subsys_props.sv
id_subsys_tb.sv
